/* project.f */
+incdir+rtl
rtl/mac_tx_data_pkg.sv
rtl/mac_tx_ctrl_pkg.sv
rtl/mac_tx_async_fifo.sv
rtl/mac_tx_nibble_fifo.sv
rtl/mac_tx_frame_gate.sv
rtl/mac_tx_top.sv
testbench/tb_mac_tx.sv

/* run_sim.sh */
#!/bin/bash
# Builds the MAC transmit testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mac_tx \
	--Mdir obj_dir \
	-f project.f

./obj_dir/Vtb_mac_tx > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
	echo "run_sim: failure reported, see $LOG"
	exit 1
fi

if ! grep -q "Simulation PASSED" "$LOG"; then
	echo "run_sim: simulation ended without a result, see $LOG"
	exit 1
fi

echo "run_sim: done"

/* testbench/tb_mac_tx.sv */
// ****************************
// Random frames through the MAC transmit path, checked on the MII
// Source writes one byte per sys_clk cycle whenever ready and not full
// ****************************

`timescale 1ns/1ps

`include "mac_tx_config.svh"

module tb_mac_tx import mac_tx_data_pkg::*; ();

	localparam int NUM_FRAMES = 10;
	localparam int FIFO_DEPTH = 1 << `MAC_TX_FIFO_AW;
	localparam int IFG = `MAC_TX_IFG_CYCLES;
	localparam logic [15:0] SEED = 16'd33405;

	logic sys_clk;
	logic phy_tx_clk;
	logic tx_rst2;
	logic stb;
	logic last;
	tx_byte_t data;
	logic full;
	logic ready;
	logic phy_tx_en;
	tx_nibble_t phy_tx_data;

	// Expected bytes, frame lengths and frame names in write order
	tx_byte_t exp_q[$];
	int len_q[$];
	string name_q[$];
	int frame_lens[NUM_FRAMES];

	logic [15:0] lfsr;
	int errors = 0;
	int bytes_checked = 0;
	int frames_done = 0;
	int cycle_limit = 0;
	int cycle_count;
	logic first_last_sent = 1'b0;

	// Full flag history of the frame being written
	logic full_seen;
	logic full_fell;
	int full_at;

	// MII monitor state
	logic prev_en = 1'b0;
	logic have_lo = 1'b0;
	tx_nibble_t lo_nib;
	int en_cycles = 0;
	int idle_cycles = 0;
	logic draining = 1'b0;

	mac_tx_top dut (
		.sys_clk(sys_clk),
		.tx_rst2(tx_rst2),
		.stb(stb),
		.data(data),
		.last(last),
		.full(full),
		.ready(ready),
		.phy_tx_clk(phy_tx_clk),
		.phy_tx_en(phy_tx_en),
		.phy_tx_data(phy_tx_data)
	);

	// 30 ns system clock
	initial begin
		sys_clk = 1'b0;
		forever #15 sys_clk = ~sys_clk;
	end

	// 40 ns MII clock offset so that no edge meets a sys_clk edge or drive time
	initial begin
		phy_tx_clk = 1'b0;
		#3;
		forever #20 phy_tx_clk = ~phy_tx_clk;
	end

	// Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken, bits packed MSB first
	function automatic int take_bits(input int n);
		int v;
		int k;
		v = 0;
		for (k = 0; k < n; k++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// Writes one frame and holds off while not ready or full
	task automatic send_frame(input int len, input string name);
		int i;
		tx_byte_t b;
		i = 0;
		len_q.push_back(len);
		name_q.push_back(name);
		full_seen = 1'b0;
		full_fell = 1'b0;
		full_at = 0;
		while (i < len) begin
			@(posedge sys_clk);
			#2;
			if (full && !full_seen) begin
				full_seen = 1'b1;
				full_at = i;
			end
			if (!full && full_seen)
				full_fell = 1'b1;
			if (ready && !full) begin
				b = tx_byte_t'(take_bits(`MAC_TX_BYTE_W));
				stb = 1'b1;
				data = b;
				last = (i == len - 1);
				exp_q.push_back(b);
				if (last)
					first_last_sent = 1'b1;
				i++;
			end else begin
				stb = 1'b0;
				last = 1'b0;
			end
		end
		@(posedge sys_clk);
		#2;
		stb = 1'b0;
		last = 1'b0;
	endtask

	// ready drops in the cycle of the last strobe
	assert property (@(posedge sys_clk) disable iff (tx_rst2) (stb && last) |-> !ready)
	else begin
		errors++;
		$display("error ready_on_last: expected 0, actual 1");
	end

	// Nothing leaves before the first frame is complete
	assert property (@(posedge phy_tx_clk) disable iff (tx_rst2) phy_tx_en |-> first_last_sent)
	else begin
		errors++;
		$display("phy_tx_en went high before the first frame was fully written");
	end

	// After a last strobe, ready may only return once the frame has left the FIFO
	// A write seen here means the source already found ready high again
	// Only the next frame's first byte may be queued by then
	always @(posedge sys_clk) begin
		if (!tx_rst2) begin
			if (draining && (ready || stb)) begin
				assert (exp_q.size() <= 1)
				else begin
					errors++;
					$display("error ready_release: expected at most 1, actual %0d",
						exp_q.size());
				end
				draining = 1'b0;
			end
			if (stb && last)
				draining = 1'b1;
		end
	end

	// MII monitor rebuilds bytes and measures bursts and gaps
	always @(posedge phy_tx_clk) begin
		if (!tx_rst2) begin
			if (phy_tx_en) begin
				if (!prev_en && frames_done > 0) begin
					assert (idle_cycles >= IFG)
					else begin
						errors++;
						$display("error gap: expected %0d, actual %0d", IFG, idle_cycles);
					end
				end
				en_cycles++;
				if (!have_lo) begin
					lo_nib = phy_tx_data;
					have_lo = 1'b1;
				end else begin
					have_lo = 1'b0;
					if (exp_q.size() == 0) begin
						errors++;
						$display("byte seen on the MII with no byte left to expect");
					end else begin
						assert ({phy_tx_data, lo_nib} == exp_q[0])
						else begin
							errors++;
							$display("error %s: expected %02h, actual %02h",
								name_q[0], exp_q[0], {phy_tx_data, lo_nib});
						end
						void'(exp_q.pop_front());
						bytes_checked++;
					end
				end
			end else begin
				// Falling phy_tx_en closes a frame
				if (prev_en) begin
					if (len_q.size() == 0) begin
						errors++;
						$display("burst on the MII without a frame written");
					end else begin
						assert (en_cycles == 2 * len_q[0])
						else begin
							errors++;
							$display("error %s: expected %0d, actual %0d",
								name_q[0], 2 * len_q[0], en_cycles);
						end
						void'(len_q.pop_front());
						void'(name_q.pop_front());
					end
					assert (!have_lo)
					else begin
						errors++;
						$display("burst ended after a low nibble without its high nibble");
					end
					have_lo = 1'b0;
					frames_done++;
					en_cycles = 0;
					idle_cycles = 0;
				end
				idle_cycles++;
			end
			prev_en = phy_tx_en;
		end
	end

	// Watchdog sized from the frame lengths
	initial begin
		cycle_count = 0;
		@(posedge phy_tx_clk);
		while (cycle_count < cycle_limit) begin
			@(posedge phy_tx_clk);
			cycle_count++;
		end
		$display("timeout after %0d phy_tx_clk cycles, %0d of %0d frames received",
			cycle_limit, frames_done, NUM_FRAMES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int total;
		int k;
		stb = 1'b0;
		last = 1'b0;
		data = '0;
		tx_rst2 = 1'b1;
		lfsr = SEED;

		// Short frame, 90 byte frame, then random lengths 1 to 40
		frame_lens[0] = 5;
		frame_lens[1] = 90;
		for (k = 2; k < NUM_FRAMES; k++)
			frame_lens[k] = take_bits(6) % 40 + 1;
		total = 0;
		for (k = 0; k < NUM_FRAMES; k++)
			total += frame_lens[k];
		cycle_limit = 4 * 2 * total + 40 * NUM_FRAMES;

		repeat (10) @(posedge sys_clk);
		#2;
		tx_rst2 = 1'b0;

		// Let the reset leave the phy_tx_clk synchronizer
		repeat (4) @(posedge phy_tx_clk);
		@(posedge sys_clk);
		#2;
		assert (!phy_tx_en)
		else begin
			errors++;
			$display("error reset_en: expected 0, actual %0b", phy_tx_en);
		end
		assert (ready)
		else begin
			errors++;
			$display("error reset_ready: expected 1, actual %0b", ready);
		end

		send_frame(frame_lens[0], "basic");

		// Long frame fills the FIFO before its last byte
		send_frame(frame_lens[1], "long");
		assert (full_seen)
		else begin
			errors++;
			$display("full never rose during the 90 byte frame");
		end
		assert (full_at == FIFO_DEPTH)
		else begin
			errors++;
			$display("error long_full: expected %0d, actual %0d", FIFO_DEPTH, full_at);
		end
		assert (full_fell)
		else begin
			errors++;
			$display("full stayed high for the rest of the 90 byte frame");
		end

		for (k = 2; k < NUM_FRAMES; k++)
			send_frame(frame_lens[k], "random");

		wait (frames_done == NUM_FRAMES);
		repeat (4) @(posedge phy_tx_clk);
		assert (exp_q.size() == 0)
		else begin
			errors++;
			$display("error final_queue: expected 0, actual %0d", exp_q.size());
		end

		$display("%0d frames, %0d bytes checked, %0d errors", frames_done, bytes_checked, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* rtl/mac_tx_top.sv */
// ****************************
// MAC transmit path, MII side
// No preamble, CRC or padding is added
// ****************************

`timescale 1ns/1ps

module mac_tx_top import mac_tx_data_pkg::*; (
	// System side
	input  logic       sys_clk,
	input  logic       tx_rst2,
	input  logic       stb,
	input  tx_byte_t   data,
	input  logic       last,
	output logic       full,
	output logic       ready,

	// MII side
	input  logic       phy_tx_clk,
	output logic       phy_tx_en,
	output tx_nibble_t phy_tx_data
);

	// Grant into the PHY domain
	logic can_tx;

	// FIFO empty, in sys_clk
	logic empty;

	mac_tx_frame_gate gate (
		.sys_clk(sys_clk),
		.tx_rst2(tx_rst2),
		.stb(stb),
		.last(last),
		.full(full),
		.empty(empty),
		.can_tx(can_tx),
		.ready(ready)
	);

	mac_tx_nibble_fifo nibble_fifo (
		.sys_clk(sys_clk),
		.tx_rst2(tx_rst2),
		.stb(stb),
		.data(data),
		.full(full),
		.can_tx(can_tx),
		.empty(empty),
		.phy_tx_clk(phy_tx_clk),
		.phy_tx_en(phy_tx_en),
		.phy_tx_data(phy_tx_data)
	);

endmodule

/* rtl/mac_tx_frame_gate.sv */
// ****************************
// Per frame grant in sys_clk
// Source writes only while ready is high and full is low
// ****************************

`timescale 1ns/1ps

module mac_tx_frame_gate import mac_tx_ctrl_pkg::*; (
	input  logic sys_clk,
	input  logic tx_rst2,

	// Source write strobes
	input  logic stb,
	input  logic last,

	// FIFO status, empty already synced into sys_clk
	input  logic full,
	input  logic empty,

	output logic can_tx,
	output logic ready
);

	gate_state_t state;
	logic empty_d;
	logic empty_rise;
	logic last_wr;

	// Final byte of the frame written this cycle
	assign last_wr = stb && last;

	// Edge only, a steady high empty may be stale
	assign empty_rise = empty && !empty_d;

	always_ff @(posedge sys_clk) begin
		if (tx_rst2) begin
			state <= gate_load;
			empty_d <= 1'b1;
		end else begin
			empty_d <= empty;
			case (state)
				gate_load: begin
					// Last byte has priority over a full FIFO
					if (last_wr)
						state <= gate_drain_wait;
					else if (full)
						state <= gate_send;
				end
				gate_send: begin
					// Long frame already on its way, wait for its end
					if (last_wr)
						state <= gate_drain_wait;
				end
				gate_drain_wait: begin
					if (empty_rise)
						state <= gate_load;
				end
				default: state <= gate_load;
			endcase
		end
	end

	// PHY side may send in both non-load states
	assign can_tx = (state != gate_load);

	// Drops with the last strobe, back once the frame has drained
	assign ready = (state != gate_drain_wait) && !last_wr;

endmodule

/* rtl/mac_tx_nibble_fifo.sv */
// ****************************
// Byte FIFO to MII nibbles, low nibble first
// FIFO must not run dry inside a frame; underrun ends the frame
// ****************************

`timescale 1ns/1ps

`include "mac_tx_config.svh"

module mac_tx_nibble_fifo import mac_tx_data_pkg::*, mac_tx_ctrl_pkg::*; (
	// System side
	input  logic       sys_clk,
	input  logic       tx_rst2,
	input  logic       stb,
	input  tx_byte_t   data,
	output logic       full,
	input  logic       can_tx,
	output logic       empty,

	// MII side
	input  logic       phy_tx_clk,
	output logic       phy_tx_en,
	output tx_nibble_t phy_tx_data
);

	localparam int FIFO_AW = $bits(fifo_ptr_t) - 1;
	localparam int NIB_W = `MAC_TX_NIBBLE_W;
	localparam int BYTE_W = `MAC_TX_BYTE_W;

	tx_byte_t fifo_out;
	logic fifo_empty;
	logic fifo_read;

	logic empty_s1;
	logic can_tx_s1;
	logic can_tx_s2;
	logic rst_s1;
	logic phy_rst;

	ser_state_t ser_state;
	tx_nibble_t hi_nib;
	ifg_count_t gap_cnt;
	logic send_ok;

	mac_tx_async_fifo #(
		.ADDR_W(FIFO_AW)
	) fifo (
		.wclk(sys_clk),
		.wrst(tx_rst2),
		.wr_en(stb),
		.wr_data(data),
		.full(full),
		.rclk(phy_tx_clk),
		.rrst(phy_rst),
		.rd_en(fifo_read),
		.rd_data(fifo_out),
		.empty(fifo_empty)
	);

	// FIFO empty back into sys_clk for the frame gate
	always_ff @(posedge sys_clk) begin
		if (tx_rst2) begin
			empty_s1 <= 1'b1;
			empty <= 1'b1;
		end else begin
			empty_s1 <= fifo_empty;
			empty <= empty_s1;
		end
	end

	// Grant level into phy_tx_clk
	always_ff @(posedge phy_tx_clk) begin
		can_tx_s1 <= can_tx;
		can_tx_s2 <= can_tx_s1;
	end

	// Reset into phy_tx_clk through two flops
	always_ff @(posedge phy_tx_clk) begin
		rst_s1 <= tx_rst2;
		phy_rst <= rst_s1;
	end

	// A byte may go out
	assign send_ok = can_tx_s2 && !fifo_empty;

	// Pop with the low nibble from idle or after a high nibble
	assign fifo_read = send_ok && (ser_state == ser_idle || ser_state == ser_hi);

	always_ff @(posedge phy_tx_clk) begin
		if (phy_rst) begin
			ser_state <= ser_idle;
			phy_tx_en <= 1'b0;
			gap_cnt <= '0;
		end else begin
			case (ser_state)
				ser_idle: begin
					// Only reached with the gap counter at zero
					if (send_ok) begin
						phy_tx_en <= 1'b1;
						ser_state <= ser_lo;
					end
				end
				ser_lo: begin
					// High nibble always follows
					ser_state <= ser_hi;
				end
				ser_hi: begin
					if (send_ok) begin
						ser_state <= ser_lo;
					end else begin
						// End of frame starts the gap
						phy_tx_en <= 1'b0;
						gap_cnt <= ifg_count_t'(`MAC_TX_IFG_CYCLES - 1);
						ser_state <= ser_gap;
					end
				end
				ser_gap: begin
					// One cycle per count down to and including zero
					if (gap_cnt == '0)
						ser_state <= ser_idle;
					else
						gap_cnt <= gap_cnt - 1'b1;
				end
				default: ser_state <= ser_idle;
			endcase
		end
	end

	// Nibble data path
	// High half is kept since the head moves on after the pop
	always_ff @(posedge phy_tx_clk) begin
		if (fifo_read) begin
			phy_tx_data <= fifo_out[NIB_W-1:0];
			hi_nib <= fifo_out[BYTE_W-1:NIB_W];
		end else if (ser_state == ser_lo) begin
			phy_tx_data <= hi_nib;
		end
	end

endmodule

/* rtl/mac_tx_async_fifo.sv */
// ****************************
// Dual clock byte FIFO with show-ahead read
// ADDR_W must be 2 or more; flags are pessimistic
// Writes while full and reads while empty are ignored
// ****************************

`timescale 1ns/1ps

`include "mac_tx_config.svh"

module mac_tx_async_fifo import mac_tx_data_pkg::*; #(
	parameter int ADDR_W = `MAC_TX_FIFO_AW
) (
	// Write side
	input  logic     wclk,
	input  logic     wrst,
	input  logic     wr_en,
	input  tx_byte_t wr_data,
	output logic     full,

	// Read side
	input  logic     rclk,
	input  logic     rrst,
	input  logic     rd_en,
	output tx_byte_t rd_data,
	output logic     empty
);

	localparam int DEPTH = 1 << ADDR_W;

	// Pointer carries one wrap bit above the address
	typedef logic [ADDR_W:0] ptr_t;

	tx_byte_t mem [DEPTH];

	// Write domain pointers
	ptr_t wbin;
	ptr_t wgray;
	ptr_t wbin_next;
	ptr_t wgray_next;
	ptr_t wq1_rgray;
	ptr_t wq2_rgray;
	logic full_next;

	// Read domain pointers
	ptr_t rbin;
	ptr_t rgray;
	ptr_t rbin_next;
	ptr_t rgray_next;
	ptr_t rq1_wgray;
	ptr_t rq2_wgray;
	logic empty_next;

	function automatic ptr_t bin2gray(input ptr_t b);
		return b ^ (b >> 1);
	endfunction

	// Write pointer advances only on an accepted write
	assign wbin_next = wbin + ptr_t'(wr_en && !full);
	assign wgray_next = bin2gray(wbin_next);

	// Full when the write pointer laps the synced read pointer
	// Top two Gray bits inverted, rest equal
	assign full_next = (wgray_next ==
		{~wq2_rgray[ADDR_W:ADDR_W-1], wq2_rgray[ADDR_W-2:0]});

	always_ff @(posedge wclk) begin
		if (wrst) begin
			wbin <= '0;
			wgray <= '0;
			full <= 1'b0;
		end else begin
			wbin <= wbin_next;
			wgray <= wgray_next;
			full <= full_next;
		end
	end

	// Byte storage
	always_ff @(posedge wclk) begin
		if (wr_en && !full)
			mem[wbin[ADDR_W-1:0]] <= wr_data;
	end

	// Read pointer into the write domain through two flops
	always_ff @(posedge wclk) begin
		if (wrst) begin
			wq1_rgray <= '0;
			wq2_rgray <= '0;
		end else begin
			wq1_rgray <= rgray;
			wq2_rgray <= wq1_rgray;
		end
	end

	// Head byte is visible while empty is low
	assign rd_data = mem[rbin[ADDR_W-1:0]];

	assign rbin_next = rbin + ptr_t'(rd_en && !empty);
	assign rgray_next = bin2gray(rbin_next);

	// Empty when the read pointer catches the synced write pointer
	assign empty_next = (rgray_next == rq2_wgray);

	always_ff @(posedge rclk) begin
		if (rrst) begin
			rbin <= '0;
			rgray <= '0;
			empty <= 1'b1;
		end else begin
			rbin <= rbin_next;
			rgray <= rgray_next;
			empty <= empty_next;
		end
	end

	// Write pointer into the read domain through two flops
	always_ff @(posedge rclk) begin
		if (rrst) begin
			rq1_wgray <= '0;
			rq2_wgray <= '0;
		end else begin
			rq1_wgray <= wgray;
			rq2_wgray <= rq1_wgray;
		end
	end

endmodule

/* rtl/mac_tx_ctrl_pkg.sv */
// ****************************
// State encodings of the transmit control
// ****************************

package mac_tx_ctrl_pkg;

	// Frame gate, sys_clk domain
	typedef enum logic [1:0] {
		gate_load,       // taking bytes, can_tx low
		gate_send,       // FIFO filled on a long frame, still taking bytes
		gate_drain_wait  // last byte written, wait for empty edge
	} gate_state_t;

	// Nibble serializer, phy_tx_clk domain
	// State names what is on the MII right now
	typedef enum logic [1:0] {
		ser_idle,
		ser_lo,
		ser_hi,
		ser_gap
	} ser_state_t;

endpackage

/* rtl/mac_tx_data_pkg.sv */
// ****************************
// Data widths of the transmit path
// Widths follow mac_tx_config.svh
// ****************************

`include "mac_tx_config.svh"

package mac_tx_data_pkg;

	// One frame byte as written by the source
	typedef logic [`MAC_TX_BYTE_W-1:0] tx_byte_t;

	// One MII nibble, phy_tx_data
	typedef logic [`MAC_TX_NIBBLE_W-1:0] tx_nibble_t;

	// FIFO pointer with wrap bit, binary or Gray
	typedef logic [`MAC_TX_FIFO_AW:0] fifo_ptr_t;

	// Interframe gap counter
	// Sized to hold the gap length minus one
	typedef logic [$clog2(`MAC_TX_IFG_CYCLES)-1:0] ifg_count_t;

endpackage

/* rtl/mac_tx_config.svh */
// ****************************
// Transmit path sizing. FIFO depth is 2**MAC_TX_FIFO_AW bytes
// Gap length must fit the gap counter width in the data package
// ****************************

`ifndef MAC_TX_CONFIG_SVH
`define MAC_TX_CONFIG_SVH

// FIFO address bits, 64 bytes deep
`define MAC_TX_FIFO_AW 6

// Frame byte width on the system side
`define MAC_TX_BYTE_W 8

// MII data width
`define MAC_TX_NIBBLE_W 4

// Minimum idle phy_tx_clk cycles after a frame
`define MAC_TX_IFG_CYCLES 24

`endif
